// File: huf_pkg.sv
// Shared widths, enums and structs for the Huffman tree builder; import into each module.
package huf_pkg;

  localparam int n_syms = 16;
  localparam int freq_w = 12;
  localparam int sym_w = 5;
  localparam int depth_w = 5;
  localparam int rebuild_w = 4;

  typedef enum logic [1:0] {
    eob_middle,
    eob_end,
    eob_last
  } eob_t;

  typedef enum logic [2:0] {
    st_idle,
    st_build,
    st_pipe_wait,
    st_check,
    st_rebuild,
    st_stall
  } htb_state_t;

  typedef struct packed {
    logic [n_syms-1:0][sym_w-1:0]  sym;
    logic [n_syms-1:0][freq_w-1:0] freq;
    logic [sym_w-1:0]              first_used;
    logic [7:0]                    seq_id;
    eob_t                          eob;
  } blk_in_t;

  typedef struct packed {
    logic [depth_w-1:0]   max_code_length;
    logic [rebuild_w-1:0] max_rebuild_limit;
  } htb_cfg_t;

  // Four extra bits so node sums never wrap.
  typedef struct packed {
    logic              is_node;
    logic [sym_w-1:0]  value;
    logic [freq_w+3:0] freq;
  } work_entry_t;

  typedef struct packed {
    logic [n_syms-1:0][depth_w-1:0] depth;
    logic                           zero_symbols;
    logic                           build_error;
    logic [7:0]                     seq_id;
    eob_t                           eob;
  } blk_out_t;

endpackage

// File: htb_freq_store.sv
// Holds the sorted input block and feeds the work table, scaled down on every rebuild.
`timescale 1ns/1ps

module htb_freq_store #(
  parameter int N_SYMS = huf_pkg::n_syms
) (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic                                  start,
  input  huf_pkg::blk_in_t                      blk_in,
  input  logic                                  start_rebuild,
  input  logic [huf_pkg::rebuild_w-1:0]         rebuild_cnt,
  output huf_pkg::work_entry_t [N_SYMS-1:0]     table_init,
  output logic [huf_pkg::sym_w-1:0]             load_row,
  output logic                                  load,
  output logic                                  zero_symbols,
  output logic [7:0]                            seq_id,
  output huf_pkg::eob_t                         eob
);
  import huf_pkg::*;

  logic [N_SYMS-1:0][sym_w-1:0]  sym_q;
  logic [N_SYMS-1:0][freq_w-1:0] freq_q;
  logic [N_SYMS-1:0][freq_w-1:0] div_freq;
  logic [sym_w-1:0]              first_used_q;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      first_used_q <= sym_w'(N_SYMS);
      seq_id       <= '0;
      eob          <= eob_middle;
    end
    else if (start)
    begin
      first_used_q <= blk_in.first_used;
      seq_id       <= blk_in.seq_id;
      eob          <= blk_in.eob;
    end
  end

  always_ff @(posedge clk)
  begin
    if (start)
    begin
      sym_q  <= blk_in.sym;
      freq_q <= blk_in.freq;
    end
  end

  // A used symbol never drops to zero.
  always_comb
  begin
    for (int i = 0; i < N_SYMS; i++)
    begin
      div_freq[i] = freq_q[i] >> rebuild_cnt;
      if (freq_q[i] != '0 && div_freq[i] == '0)
        div_freq[i] = freq_w'(1);
    end
  end

  // The original block goes straight through on start.
  always_comb
  begin
    for (int i = 0; i < N_SYMS; i++)
    begin
      table_init[i].is_node = 1'b0;
      table_init[i].value   = start ? blk_in.sym[i] : sym_q[i];
      table_init[i].freq    = {4'b0, (start ? blk_in.freq[i] : div_freq[i])};
    end
  end

  assign load_row     = start ? blk_in.first_used : first_used_q;
  assign load         = start | start_rebuild;
  assign zero_symbols = (first_used_q == sym_w'(N_SYMS));

endmodule

// File: htb_merge_engine.sv
// Sorted work table with a pending node; merges the two smallest entries each build cycle.
`timescale 1ns/1ps

module htb_merge_engine #(
  parameter int N_SYMS = huf_pkg::n_syms
) (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               load,
  input  huf_pkg::work_entry_t [N_SYMS-1:0]  table_init,
  input  logic [huf_pkg::sym_w-1:0]          load_row,
  input  huf_pkg::htb_state_t                state,
  output huf_pkg::work_entry_t [1:0]         pick,
  output logic [huf_pkg::sym_w-1:0]          pick_node,
  output logic                               pick_valid,
  output logic                               tree_done
);
  import huf_pkg::*;

  localparam logic [sym_w-1:0] last_merge_row = sym_w'(N_SYMS - 2);

  work_entry_t [N_SYMS-1:0] tbl;
  work_entry_t [N_SYMS-1:0] tbl_nxt;
  work_entry_t [N_SYMS-1:0] below;
  work_entry_t              pend;
  work_entry_t              pend_nxt;
  work_entry_t              init_pend;
  work_entry_t              ent_a;
  work_entry_t              ent_b;
  work_entry_t              first_pick;
  work_entry_t              second_pick;
  logic [sym_w-1:0]         rp;
  logic                     merge;
  logic                     has_b;
  logic                     take_b;

  // Rows above rp are live; the row at rp itself already sits in pend.
  assign merge     = (state == st_build) && (rp <= last_merge_row);
  assign tree_done = (rp >= last_merge_row);
  assign has_b     = (rp < last_merge_row);

  always_comb
  begin
    init_pend = '0;
    ent_a     = '0;
    ent_b     = '0;
    for (int i = 0; i < N_SYMS; i++)
    begin
      if (sym_w'(i) == load_row)
        init_pend = table_init[i];
      if (sym_w'(i) == rp + sym_w'(1))
        ent_a = tbl[i];
      if (sym_w'(i) == rp + sym_w'(2))
        ent_b = tbl[i];
    end
  end

  // Two smallest of pend and the next two rows.
  always_comb
  begin
    take_b = has_b && (ent_b.freq < pend.freq);
    if (pend.freq <= ent_a.freq)
    begin
      first_pick  = pend;
      second_pick = ent_a;
    end
    else if (!take_b)
    begin
      first_pick  = ent_a;
      second_pick = pend;
    end
    else
    begin
      first_pick  = ent_a;
      second_pick = ent_b;
    end
    pend_nxt.is_node = 1'b1;
    pend_nxt.value   = rp;
    pend_nxt.freq    = first_pick.freq + second_pick.freq;
  end

  // When both rows are taken, the old pend drops into the table.
  always_comb
  begin
    for (int i = 0; i < N_SYMS - 1; i++)
      below[i] = tbl[i+1];
    below[N_SYMS-1] = '{is_node: 1'b0, value: '0, freq: '1};
    tbl_nxt = tbl;
    if (take_b)
    begin
      for (int i = 0; i < N_SYMS; i++)
      begin
        if (sym_w'(i) >= rp + sym_w'(2))
        begin
          if (below[i].freq < pend.freq)
            tbl_nxt[i] = below[i];
          else if (tbl[i].freq < pend.freq)
            tbl_nxt[i] = pend;
        end
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rp         <= '0;
      pick_valid <= 1'b0;
    end
    else
    begin
      pick_valid <= merge;
      if (load)
        rp <= load_row;
      else if (merge)
        rp <= rp + sym_w'(1);
    end
  end

  always_ff @(posedge clk)
  begin
    if (load)
    begin
      tbl  <= table_init;
      pend <= init_pend;
    end
    else if (merge)
    begin
      tbl       <= tbl_nxt;
      pend      <= pend_nxt;
      pick[0]   <= first_pick;
      pick[1]   <= second_pick;
      pick_node <= rp;
    end
  end

endmodule

// File: htb_depth_tracker.sv
// Follows every symbol up the tree as nodes are merged and counts its code length.
`timescale 1ns/1ps

module htb_depth_tracker #(
  parameter int N_SYMS = huf_pkg::n_syms
) (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  logic                                   clear,
  input  huf_pkg::work_entry_t [1:0]             pick,
  input  logic [huf_pkg::sym_w-1:0]              pick_node,
  input  logic                                   pick_valid,
  input  logic [huf_pkg::depth_w-1:0]            max_code_length,
  output logic                                   over_limit,
  output logic [N_SYMS-1:0][huf_pkg::depth_w-1:0] depth
);
  import huf_pkg::*;

  logic [N_SYMS-1:0][sym_w-1:0]   node_of;
  logic [N_SYMS-1:0][sym_w-1:0]   node_of_nxt;
  logic [N_SYMS-1:0][depth_w-1:0] depth_nxt;
  logic [N_SYMS-1:0]              in_tree;
  logic [N_SYMS-1:0]              in_tree_nxt;

  always_comb
  begin
    in_tree_nxt = in_tree;
    node_of_nxt = node_of;
    depth_nxt   = depth;
    for (int s = 0; s < N_SYMS; s++)
    begin
      for (int j = 0; j < 2; j++)
      begin
        if (!pick[j].is_node && pick[j].value == sym_w'(s))
        begin
          in_tree_nxt[s] = 1'b1;
          node_of_nxt[s] = pick_node;
          depth_nxt[s]   = depth_w'(1);
        end
        else if (pick[j].is_node && in_tree[s] && node_of[s] == pick[j].value)
        begin
          // Whole subtree moves one level down.
          node_of_nxt[s] = pick_node;
          depth_nxt[s]   = depth[s] + depth_w'(1);
        end
      end
    end
  end

  always_comb
  begin
    over_limit = 1'b0;
    for (int s = 0; s < N_SYMS; s++)
      if (depth[s] > max_code_length)
        over_limit = 1'b1;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      in_tree <= '0;
      depth   <= '0;
    end
    else if (clear)
    begin
      in_tree <= '0;
      depth   <= '0;
    end
    else if (pick_valid)
    begin
      in_tree <= in_tree_nxt;
      depth   <= depth_nxt;
    end
  end

  always_ff @(posedge clk)
  begin
    if (pick_valid && !clear)
      node_of <= node_of_nxt;
  end

endmodule

// File: htb_ctrl.sv
// Block FSM of the tree builder: build, check, rebuild, stall on hold and signal done.
`timescale 1ns/1ps

module htb_ctrl #(
  parameter int N_SYMS = huf_pkg::n_syms
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          start,
  input  logic                          zero_symbols,
  input  logic                          tree_done,
  input  logic                          over_limit,
  input  huf_pkg::htb_cfg_t             cfg,
  input  logic                          hold,
  output huf_pkg::htb_state_t           state,
  output logic [huf_pkg::rebuild_w-1:0] rebuild_cnt,
  output logic                          start_rebuild,
  output logic                          busy,
  output logic                          done,
  output logic                          build_error,
  output logic                          rebuild_pulse
);
  import huf_pkg::*;

  htb_state_t nxt_state;
  logic       fail_now;
  logic       take_start;

  assign take_start    = (state == st_idle) && start;
  assign fail_now      = (state == st_check) && over_limit &&
                         (rebuild_cnt >= cfg.max_rebuild_limit);
  assign start_rebuild = (state == st_rebuild);
  assign busy          = (state != st_idle);

  always_comb
  begin
    nxt_state = state;
    case (state)
      st_idle:
        if (start)
          nxt_state = st_build;
      st_build:
        if (zero_symbols)
          nxt_state = hold ? st_stall : st_idle;
        else if (tree_done)
          nxt_state = st_pipe_wait;
      st_pipe_wait:
        nxt_state = st_check;
      st_check:
        if (over_limit && !fail_now)
          nxt_state = st_rebuild;
        else if (hold)
          nxt_state = st_stall;
        else
          nxt_state = st_idle;
      st_rebuild:
        nxt_state = st_build;
      st_stall:
        if (!hold)
          nxt_state = st_idle;
      default:
        nxt_state = st_idle;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state         <= st_idle;
      rebuild_cnt   <= '0;
      done          <= 1'b0;
      build_error   <= 1'b0;
      rebuild_pulse <= 1'b0;
    end
    else
    begin
      state         <= nxt_state;
      done          <= (state != st_idle) && (nxt_state == st_idle);
      rebuild_pulse <= (state == st_rebuild);
      // Counter and error flag live until the next block.
      if (take_start)
      begin
        rebuild_cnt <= '0;
        build_error <= 1'b0;
      end
      else
      begin
        if (state == st_check && nxt_state == st_rebuild)
          rebuild_cnt <= rebuild_cnt + rebuild_w'(1);
        if (fail_now)
          build_error <= 1'b1;
      end
    end
  end

endmodule

// File: htb_top.sv
// Top level of the length-limited Huffman tree builder; instantiate this as the DUT.
`timescale 1ns/1ps

module htb_top #(
  parameter int N_SYMS = huf_pkg::n_syms
) (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               start,
  input  huf_pkg::blk_in_t   blk_in,
  input  huf_pkg::htb_cfg_t  cfg,
  input  logic               hold,
  output logic               busy,
  output logic               done,
  output huf_pkg::blk_out_t  result,
  output logic               rebuild_pulse
);
  import huf_pkg::*;

  work_entry_t [N_SYMS-1:0]       table_init;
  work_entry_t [1:0]              pick;
  logic [sym_w-1:0]               load_row;
  logic [sym_w-1:0]               pick_node;
  logic [rebuild_w-1:0]           rebuild_cnt;
  logic [N_SYMS-1:0][depth_w-1:0] depth;
  logic [7:0]                     seq_id;
  eob_t                           eob;
  htb_state_t                     state;
  logic                           load;
  logic                           zero_symbols;
  logic                           pick_valid;
  logic                           tree_done;
  logic                           over_limit;
  logic                           start_rebuild;
  logic                           build_error;

  assign result = '{depth: depth, zero_symbols: zero_symbols, build_error: build_error,
                    seq_id: seq_id, eob: eob};

  htb_freq_store #(.N_SYMS(N_SYMS)) htb_freq_store_i (
    .clk(clk), .rst_n(rst_n), .start(start), .blk_in(blk_in),
    .start_rebuild(start_rebuild), .rebuild_cnt(rebuild_cnt),
    .table_init(table_init), .load_row(load_row), .load(load),
    .zero_symbols(zero_symbols), .seq_id(seq_id), .eob(eob)
  );

  htb_merge_engine #(.N_SYMS(N_SYMS)) htb_merge_engine_i (
    .clk(clk), .rst_n(rst_n), .load(load), .table_init(table_init),
    .load_row(load_row), .state(state), .pick(pick), .pick_node(pick_node),
    .pick_valid(pick_valid), .tree_done(tree_done)
  );

  htb_depth_tracker #(.N_SYMS(N_SYMS)) htb_depth_tracker_i (
    .clk(clk), .rst_n(rst_n), .clear(load), .pick(pick), .pick_node(pick_node),
    .pick_valid(pick_valid), .max_code_length(cfg.max_code_length),
    .over_limit(over_limit), .depth(depth)
  );

  htb_ctrl #(.N_SYMS(N_SYMS)) htb_ctrl_i (
    .clk(clk), .rst_n(rst_n), .start(start), .zero_symbols(zero_symbols),
    .tree_done(tree_done), .over_limit(over_limit), .cfg(cfg), .hold(hold),
    .state(state), .rebuild_cnt(rebuild_cnt), .start_rebuild(start_rebuild),
    .busy(busy), .done(done), .build_error(build_error), .rebuild_pulse(rebuild_pulse)
  );

endmodule

// File: htb_assert.sv
// Bound checks on the done pulse, busy level and hold stall; bind target is htb_top.
`timescale 1ns/1ps

module htb_check_assert (
  input logic clk,
  input logic rst_n,
  input logic start,
  input logic hold,
  input logic busy,
  input logic done
);

  // No completion while downstream holds.
  done_under_hold: assert property (@(posedge clk) disable iff (!rst_n) hold |-> !done)
    else $error("done high while hold is high");

  done_one_cycle: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
    else $error("done longer than one cycle");

  busy_under_hold: assert property (@(posedge clk) disable iff (!rst_n)
                                    (busy && hold) |=> busy)
    else $error("busy dropped while hold is high");

  // An accepted start opens the block.
  start_sets_busy: assert property (@(posedge clk) disable iff (!rst_n)
                                    (start && !busy) |=> busy)
    else $error("busy not raised after start");

endmodule

bind htb_top htb_check_assert htb_check_assert_i (
  .clk(clk), .rst_n(rst_n), .start(start), .hold(hold), .busy(busy), .done(done)
);

// File: tb_htb.sv
// Testbench for the Huffman tree builder; reads blocks from htb_stim.txt and checks each result.
`timescale 1ns/1ps

module tb_htb;
  import huf_pkg::*;

  localparam int blk_words = 41;
  localparam int max_blocks = 8;
  localparam int done_timeout = 500;
  localparam int idx_w = $clog2(n_syms);

  logic     clk;
  logic     rst_n;
  logic     start;
  logic     hold;
  logic     busy;
  logic     done;
  logic     rebuild_pulse;
  blk_in_t  blk_in;
  htb_cfg_t cfg;
  blk_out_t result;

  logic [15:0] stim [0:max_blocks*blk_words];
  int          errors;
  int          timeouts;

  htb_top #(.N_SYMS(n_syms)) htb_top_i (
    .clk(clk), .rst_n(rst_n), .start(start), .blk_in(blk_in), .cfg(cfg),
    .hold(hold), .busy(busy), .done(done), .result(result),
    .rebuild_pulse(rebuild_pulse)
  );

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp)
    begin
      errors++;
      $display("error %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic wait_idle(input int blk, output logic ok);
    int n;
    n = 0;
    while (busy && n < done_timeout)
    begin
      @(negedge clk);
      n++;
    end
    ok = !busy;
    if (!ok)
    begin
      timeouts++;
      $display("timeout: DUT still busy before block %0d", blk);
    end
  endtask

  // Block words: header at base, symbol rows at base+9, frequency rows after them.
  task automatic load_block(input int base);
    logic [idx_w-1:0] row;
    cfg.max_code_length   = stim[base][depth_w-1:0];
    cfg.max_rebuild_limit = stim[base+1][rebuild_w-1:0];
    blk_in.first_used     = stim[base+2][sym_w-1:0];
    blk_in.seq_id         = stim[base+3][7:0];
    blk_in.eob            = eob_t'(stim[base+4][1:0]);
    for (int r = 0; r < n_syms; r++)
    begin
      row = idx_w'(r);
      blk_in.sym[row]  = stim[base+9+r][sym_w-1:0];
      blk_in.freq[row] = stim[base+9+n_syms+r][freq_w-1:0];
    end
  endtask

  task automatic check_result(input int base, input int pulses);
    logic [idx_w-1:0] sym_idx;
    int               first_used;
    int               d;
    int               kraft;
    int               used;
    first_used = int'(stim[base+2]);
    kraft = 0;
    used = 0;
    check_value("result.zero_symbols", 32'(result.zero_symbols), 32'(stim[base+6]));
    check_value("result.build_error", 32'(result.build_error), 32'(stim[base+7]));
    check_value("result.seq_id", 32'(result.seq_id), 32'(stim[base+3][7:0]));
    check_value("result.eob", 32'(result.eob), 32'(stim[base+4][1:0]));
    check_value("rebuild_pulse count at minimum", 32'(pulses >= int'(stim[base+8])), 32'd1);
    for (int r = 0; r < n_syms; r++)
    begin
      sym_idx = stim[base+9+r][idx_w-1:0];
      d = int'(result.depth[sym_idx]);
      if (r < first_used)
        check_value($sformatf("result.depth[%0d]", sym_idx), 32'(d), 32'd0);
      else if (stim[base+7] == 16'd0)
      begin
        used++;
        check_value($sformatf("result.depth[%0d] over max", sym_idx),
                    32'(d > int'(stim[base][depth_w-1:0])), 32'd0);
        if (d <= 16)
          kraft += 1 << (16 - d);
      end
    end
    // Complete prefix code.
    if (used > 0)
      check_value("kraft sum of result.depth", 32'(kraft), 32'h10000);
  endtask

  task automatic run_block(input int blk, input int base);
    int   hold_cycles;
    int   cycles;
    int   pulses;
    logic seen;
    logic held;
    hold_cycles = int'(stim[base+5]);
    cycles = 0;
    pulses = 0;
    seen = 1'b0;
    load_block(base);
    start = 1'b1;
    hold = (hold_cycles != 0);
    @(negedge clk);
    start = 1'b0;
    while (!seen && cycles < hold_cycles + done_timeout)
    begin
      if (cycles >= hold_cycles)
        hold = 1'b0;
      held = hold;
      @(negedge clk);
      cycles++;
      if (rebuild_pulse)
        pulses++;
      if (done)
      begin
        seen = 1'b1;
        check_value("done while hold high", 32'(held), 32'd0);
      end
    end
    if (!seen)
    begin
      timeouts++;
      hold = 1'b0;
      $display("timeout: no done pulse for block %0d after %0d cycles", blk, cycles);
    end
    else
    begin
      check_result(base, pulses);
      // Only one done per block.
      repeat (3)
      begin
        @(negedge clk);
        check_value("done after block end", 32'(done), 32'd0);
      end
    end
  endtask

  initial
  begin
    int   n_blocks;
    int   base;
    logic ok;
    errors = 0;
    timeouts = 0;
    rst_n = 1'b0;
    start = 1'b0;
    hold = 1'b0;
    blk_in = '0;
    cfg = '0;
    $readmemh("htb_stim.txt", stim);
    n_blocks = int'(stim[0]);
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    for (int b = 0; b < n_blocks; b++)
    begin
      base = 1 + b * blk_words;
      wait_idle(b, ok);
      if (ok)
        run_block(b, base);
    end
    $display("errors: %0d value mismatches, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

endmodule

// File: htb_stim.txt
// Block count, then per block: max_code_length max_rebuild_limit first_used seq_id eob
// hold_cycles exp_zero_symbols exp_build_error min_rebuilds; symbol row line; freq row line.
6
f 3 8 11 0 20 0 0 0
3 9 0 c 5 e 1 7 a 2 f 4 8 b 6 d
0 0 0 0 0 0 0 0 3 5 6 9 c 14 1f 40
4 f 0 22 1 6 0 0 0
f e d c b a 9 8 7 6 5 4 3 2 1 0
10 10 11 11 12 12 13 13 14 14 15 15 16 16 17 17
f 3 10 33 2 0 1 0 0
0 1 2 3 4 5 6 7 8 9 a b c d e f
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
f 3 10 44 0 5 1 0 0
f e d c b a 9 8 7 6 5 4 3 2 1 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
2 2 a 55 1 30 0 1 2
0 1 2 3 4 5 6 7 8 9 b d f a c e
0 0 0 0 0 0 0 0 0 0 1 1 2 3 5 8
5 f 8 66 2 28 0 0 2
1 3 5 7 9 b d f 0 2 4 6 8 a c e
0 0 0 0 0 0 0 0 1 2 4 8 10 20 40 80

// File: vlog.f
huf_pkg.sv
htb_freq_store.sv
htb_merge_engine.sv
htb_depth_tracker.sv
htb_ctrl.sv
htb_top.sv
htb_assert.sv
tb_htb.sv

// File: run.sh
#!/usr/bin/env bash
# Compile and run the tree builder testbench with Verilator.
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f vlog.f --top-module tb_htb -o tb_htb_sim; then
  echo "Verilator compile failed"
  exit 1
fi

sim_out=$(./obj_dir/tb_htb_sim 2>&1)
sim_status=$?
echo "$sim_out"

if [ "$sim_status" -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "TB PASSED" <<< "$sim_out"; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1
